// ==== execUnit.f ====
+incdir+hw
hw/execPkg.sv
hw/alu.sv
hw/regFile.sv
hw/mulUnit.sv
hw/wbArbiter.sv
hw/execUnit.sv
sim/execUnit_props.sv
sim/execUnit_tb.sv

// ==== hw/alu.sv ====
//--------------------
// ALU
// Combinational MIPS integer functions with
// carry, zero, overflow and negative flags
//--------------------
`timescale 1ns/100ps
`include "execUnit_defs.svh"

module alu (
    input  execPkg::word_t    A,
    input  execPkg::word_t    B,
    input  execPkg::shamt_t   Shamt,
    input  execPkg::aluFunc_e ALUfunc,
    output execPkg::word_t    Out,
    output logic              En,
    output execPkg::flags_t   flags
);

    localparam int Msb = `EXEC_XLEN - 1;

    // Leading run of bitVal from the MSB
    function automatic execPkg::word_t leadCount(execPkg::word_t v, logic bitVal);
        execPkg::word_t cnt;
        logic           done;
        cnt  = '0;
        done = 1'b0;
        for (int i = Msb; i >= 0; i--)
        begin
            if (!done && (v[i] == bitVal))
                cnt = cnt + 1'b1;
            else
                done = 1'b1;
        end
        return cnt;
    endfunction

    always_comb
    begin
        Out     = '0;
        En      = 1'b1;
        flags.c = 1'b0;
        flags.o = 1'b0;

        case (ALUfunc)
            execPkg::ALU_ADD:
            begin
                {flags.c, Out} = A + B;
                flags.o = (A[Msb] == B[Msb]) && (Out[Msb] != A[Msb]);
            end

            execPkg::ALU_ADDU:
            begin
                {flags.c, Out} = A + B;
                flags.o = flags.c;   // Unsigned wrap
            end

            execPkg::ALU_SUB:
            begin
                {flags.c, Out} = A - B;
                flags.o = (A[Msb] != B[Msb]) && (Out[Msb] != A[Msb]);
            end

            execPkg::ALU_SUBU:
            begin
                {flags.c, Out} = A - B;
                flags.o = flags.c;
            end

            // Variable shifts use low bits of rs
            execPkg::ALU_SLL  : Out = B << Shamt;
            execPkg::ALU_SLLV : Out = B << A[execPkg::ShAw-1:0];
            execPkg::ALU_SRA  : Out = $signed(B) >>> Shamt;
            execPkg::ALU_SRAV : Out = $signed(B) >>> A[execPkg::ShAw-1:0];
            execPkg::ALU_SRL  : Out = B >> Shamt;
            execPkg::ALU_SRLV : Out = B >> A[execPkg::ShAw-1:0];
            execPkg::ALU_AND  : Out = A & B;
            execPkg::ALU_OR   : Out = A | B;
            execPkg::ALU_XOR  : Out = A ^ B;
            execPkg::ALU_NOR  : Out = ~(A | B);

            execPkg::ALU_MOVN:
            begin
                Out = A;
                En  = (B != '0);
            end

            execPkg::ALU_MOVZ:
            begin
                Out = A;
                En  = (B == '0);
            end

            execPkg::ALU_SLT  : Out = execPkg::word_t'($signed(A) < $signed(B));
            execPkg::ALU_SLTU : Out = execPkg::word_t'(A < B);
            execPkg::ALU_CLZ  : Out = leadCount(A, 1'b0);
            execPkg::ALU_CLO  : Out = leadCount(A, 1'b1);

            execPkg::ALU_MUL:
            begin
                Out = '0;   // Product comes from mulUnit
                En  = 1'b0;
            end

            default:
                En = 1'b0;  // Unknown code writes nothing
        endcase

        flags.n = Out[Msb];
        flags.z = (Out == '0);
    end

endmodule

// ==== hw/execPkg.sv ====
//--------------------
// Execute cluster types
// ALU function codes, issue packet, writeback request and flags
//--------------------
`include "execUnit_defs.svh"

package execPkg;

    localparam int RegAw = $clog2(`EXEC_NREGS);
    localparam int ShAw  = $clog2(`EXEC_XLEN);

    typedef logic [`EXEC_XLEN-1:0] word_t;
    typedef logic [RegAw-1:0]      regAddr_t;
    typedef logic [ShAw-1:0]       shamt_t;

    // MIPS SPECIAL function field, spare codes for CLZ/CLO/MUL
    typedef enum logic [5:0] {
        ALU_SLL  = 6'h00,
        ALU_SRL  = 6'h02,
        ALU_SRA  = 6'h03,
        ALU_SLLV = 6'h04,
        ALU_SRLV = 6'h06,
        ALU_SRAV = 6'h07,
        ALU_MOVZ = 6'h0A,
        ALU_MOVN = 6'h0B,
        ALU_CLZ  = 6'h14,
        ALU_CLO  = 6'h15,
        ALU_MUL  = 6'h1C,
        ALU_ADD  = 6'h20,
        ALU_ADDU = 6'h21,
        ALU_SUB  = 6'h22,
        ALU_SUBU = 6'h23,
        ALU_AND  = 6'h24,
        ALU_OR   = 6'h25,
        ALU_XOR  = 6'h26,
        ALU_NOR  = 6'h27,
        ALU_SLT  = 6'h2A,
        ALU_SLTU = 6'h2B
    } aluFunc_e;

    typedef struct packed {
        aluFunc_e func;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        shamt_t   shamt;
    } issue_t;

    typedef struct packed {
        logic c;   // Carry / borrow
        logic z;
        logic o;
        logic n;
    } flags_t;

    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        word_t    data;
    } wbReq_t;

endpackage

// ==== hw/execUnit.sv ====
//--------------------
// Integer execute cluster
// Register file, ALU and multiplier sharing one
// writeback port; each write is also the commit
//--------------------
`timescale 1ns/100ps
`include "execUnit_defs.svh"

module execUnit (
    input  logic            clk,
    input  logic            arstN,
    input  logic            issueValid,
    input  execPkg::issue_t issue,
    output execPkg::wbReq_t commit,
    output logic            stall,
    output logic            ovfTrap,
    output execPkg::flags_t condFlags
);

    execPkg::word_t  rsData;
    execPkg::word_t  rtData;
    execPkg::word_t  aluOut;
    execPkg::flags_t aluFlags;
    execPkg::wbReq_t mulRes;

    logic aluEn;
    logic accept;
    logic isMul;
    logic isSigned;

    assign accept   = issueValid && !stall;   // Held issue retried by issuer
    assign isMul    = (issue.func == execPkg::ALU_MUL);
    assign isSigned = (issue.func == execPkg::ALU_ADD) || (issue.func == execPkg::ALU_SUB);

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .rsAddr (issue.rs),
        .rtAddr (issue.rt),
        .wr     (commit),
        .rsData (rsData),
        .rtData (rtData)
    );

    alu uAlu (
        .A       (rsData),
        .B       (rtData),
        .Shamt   (issue.shamt),
        .ALUfunc (issue.func),
        .Out     (aluOut),
        .En      (aluEn),
        .flags   (aluFlags)
    );

    mulUnit #(
        .Stages (`EXEC_MULSTAGES)
    ) uMul (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (accept && isMul),
        .rd      (issue.rd),
        .A       (rsData),
        .B       (rtData),
        .res     (mulRes)
    );

    wbArbiter uArb (
        .clk         (clk),
        .arstN       (arstN),
        .aluValid    (accept && !isMul),
        .aluRd       (issue.rd),
        .aluData     (aluOut),
        .aluEn       (aluEn),
        .aluFlags    (aluFlags),
        .aluIsSigned (isSigned),
        .mulRes      (mulRes),
        .wr          (commit),
        .stall       (stall),
        .ovfTrap     (ovfTrap),
        .condFlags   (condFlags)
    );

endmodule

// ==== hw/execUnit_defs.svh ====
//--------------------
// Execute cluster sizing
// Data width, register count and multiplier latency
//--------------------
`ifndef EXEC_UNIT_DEFS_SVH
`define EXEC_UNIT_DEFS_SVH

`define EXEC_XLEN      32
`define EXEC_NREGS     32
`define EXEC_MULSTAGES 3   // Cycles from accept to product

`endif

// ==== hw/mulUnit.sv ====
//--------------------
// Pipelined multiplier
// Low half of a 32x32 product, destination tag
// carried alongside through every stage
//--------------------
`timescale 1ns/100ps
`include "execUnit_defs.svh"

module mulUnit #(
    parameter int Stages = `EXEC_MULSTAGES
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  execPkg::regAddr_t rd,
    input  execPkg::word_t    A,
    input  execPkg::word_t    B,
    output execPkg::wbReq_t   res
);

    logic [Stages-1:0] vld;
    execPkg::regAddr_t tag  [Stages];
    execPkg::word_t    prod [Stages];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            vld <= '0;
        else
        begin
            vld[0] <= inValid;
            for (int i = 1; i < Stages; i++)
                vld[i] <= vld[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        tag[0]  <= rd;
        prod[0] <= A * B;   // Multiply in the first stage
        for (int i = 1; i < Stages; i++)
        begin
            tag[i]  <= tag[i-1];
            prod[i] <= prod[i-1];
        end
    end

    assign res.valid = vld[Stages-1];
    assign res.rd    = tag[Stages-1];
    assign res.data  = prod[Stages-1];

endmodule

// ==== hw/regFile.sv ====
//--------------------
// Register file
// Two asynchronous reads, one clocked write, r0 fixed at zero
//--------------------
`timescale 1ns/100ps
`include "execUnit_defs.svh"

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  execPkg::regAddr_t rsAddr,
    input  execPkg::regAddr_t rtAddr,
    input  execPkg::wbReq_t   wr,
    output execPkg::word_t    rsData,
    output execPkg::word_t    rtData
);

    execPkg::word_t regs [`EXEC_NREGS];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `EXEC_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wr.valid && (wr.rd != '0))
        begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Old value is seen during the write cycle
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

// ==== hw/wbArbiter.sv ====
//--------------------
// Writeback arbiter
// One-entry ALU slot sharing the write port with the
// multiplier, which has priority; trap pulse and flags
//--------------------
`timescale 1ns/100ps

module wbArbiter (
    input  logic              clk,
    input  logic              arstN,
    input  logic              aluValid,
    input  execPkg::regAddr_t aluRd,
    input  execPkg::word_t    aluData,
    input  logic              aluEn,
    input  execPkg::flags_t   aluFlags,
    input  logic              aluIsSigned,
    input  execPkg::wbReq_t   mulRes,
    output execPkg::wbReq_t   wr,
    output logic              stall,
    output logic              ovfTrap,
    output execPkg::flags_t   condFlags
);

    logic              slotValid;
    execPkg::regAddr_t slotRd;
    execPkg::word_t    slotData;

    logic mulHit;
    logic aluTrap;
    logic aluKeep;

    assign mulHit  = mulRes.valid && (mulRes.rd != '0);   // r0 products dropped
    assign aluTrap = aluIsSigned && aluFlags.o;
    assign aluKeep = aluValid && aluEn && !aluTrap && (aluRd != '0);

    // Slot waits while the multiplier owns the port
    assign stall = slotValid && mulHit;

    // -------------------- Write port mux
    always_comb
    begin
        if (mulHit)
            wr = mulRes;
        else
        begin
            wr.valid = slotValid;
            wr.rd    = slotRd;
            wr.data  = slotData;
        end
    end

    // -------------------- Slot and status
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            slotValid <= 1'b0;
            ovfTrap   <= 1'b0;
            condFlags <= '0;
        end
        else
        begin
            if (aluValid)
                slotValid <= aluKeep;
            else if (!mulHit)
                slotValid <= 1'b0;   // Drained or already empty

            ovfTrap <= aluValid && aluTrap;

            if (aluValid)
                condFlags <= aluFlags;   // Suppressed ops too
        end
    end

    always_ff @(posedge clk)
    begin
        if (aluValid)
        begin
            slotRd   <= aluRd;
            slotData <= aluData;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert -Wno-fatal -f execUnit.f \
    --top-module execUnit_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$OBJ/VexecUnit_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
exit 1

// ==== sim/execUnit_props.sv ====
//--------------------
// Writeback arbiter properties
// Stall, trap pulse and r0 write checks
//--------------------
`timescale 1ns/100ps

module execUnit_props (
    input logic              clk,
    input logic              arstN,
    input logic              slotValid,
    input execPkg::regAddr_t slotRd,
    input logic              stall,
    input logic              ovfTrap,
    input execPkg::wbReq_t   wr
);

    // Stalled result stays in the slot
    stallHoldsSlot: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> slotValid && $stable(slotRd))
        else $error("ALU slot lost or overwritten while stalled");

    trapIsPulse: assert property (@(posedge clk) disable iff (!arstN)
        ovfTrap |=> !ovfTrap)
        else $error("ovfTrap held longer than one cycle");

    noWriteToZero: assert property (@(posedge clk) disable iff (!arstN)
        wr.valid |-> (wr.rd != '0))
        else $error("write port valid for r0");

endmodule

bind wbArbiter execUnit_props uProps (
    .clk       (clk),
    .arstN     (arstN),
    .slotValid (slotValid),
    .slotRd    (slotRd),
    .stall     (stall),
    .ovfTrap   (ovfTrap),
    .wr        (wr)
);

// ==== sim/execUnit_tb.sv ====
//--------------------
// Execute cluster testbench
// Table driven ALU ops, MUL burst, writeback collision
//--------------------
`timescale 1ns/100ps
`include "execUnit_defs.svh"

module execUnit_tb;

    localparam int TableLen      = 32;
    localparam int PreloadOps    = 4 * 64 + 4;
    localparam int MaxGap        = 2;
    localparam int TimeoutCycles = (PreloadOps + TableLen + 16) * (MaxGap + `EXEC_MULSTAGES + 4);

    typedef struct packed {
        execPkg::word_t  out;
        logic            en;
        execPkg::flags_t fl;
    } aluRes_t;

    typedef struct packed {
        execPkg::issue_t op;
        int              gap;
    } entry_t;

    logic            clk;
    logic            arstN;
    logic            issueValid;
    execPkg::issue_t issue;
    execPkg::wbReq_t commit;
    logic            stall;
    logic            ovfTrap;
    execPkg::flags_t condFlags;

    execPkg::word_t model [`EXEC_NREGS];
    entry_t         opTable [$];
    integer         seed;
    int             errors;
    int             tests;
    int             cycles;

    execUnit dut (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .issue      (issue),
        .commit     (commit),
        .stall      (stall),
        .ovfTrap    (ovfTrap),
        .condFlags  (condFlags)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TimeoutCycles)
        begin
            $display("Timeout: run exceeded %0d cycles", TimeoutCycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // -------------------- Reference model
    function automatic aluRes_t refAlu(execPkg::aluFunc_e f, execPkg::word_t a,
                                       execPkg::word_t b, execPkg::shamt_t sh);
        aluRes_t     r;
        logic [32:0] wide;
        longint      sum;
        int          k;
        r.out = '0;
        r.en  = 1'b1;
        r.fl  = '0;
        k     = 0;
        case (f)
            execPkg::ALU_ADD, execPkg::ALU_ADDU:
            begin
                wide     = {1'b0, a} + {1'b0, b};
                sum      = longint'($signed(a)) + longint'($signed(b));
                r.out    = wide[31:0];
                r.fl.c   = wide[32];
                // Signed sum outside the 32-bit range
                r.fl.o   = (f == execPkg::ALU_ADD) ?
                           (sum != longint'($signed(r.out))) : wide[32];
            end
            execPkg::ALU_SUB, execPkg::ALU_SUBU:
            begin
                wide     = {1'b0, a} - {1'b0, b};
                sum      = longint'($signed(a)) - longint'($signed(b));
                r.out    = wide[31:0];
                r.fl.c   = wide[32];   // Borrow
                r.fl.o   = (f == execPkg::ALU_SUB) ?
                           (sum != longint'($signed(r.out))) : wide[32];
            end
            execPkg::ALU_SLL  : r.out = b << sh;
            execPkg::ALU_SLLV : r.out = b << a[4:0];
            execPkg::ALU_SRL  : r.out = b >> sh;
            execPkg::ALU_SRLV : r.out = b >> a[4:0];
            execPkg::ALU_SRA  : r.out = $signed(b) >>> sh;
            execPkg::ALU_SRAV : r.out = $signed(b) >>> a[4:0];
            execPkg::ALU_AND  : r.out = a & b;
            execPkg::ALU_OR   : r.out = a | b;
            execPkg::ALU_XOR  : r.out = a ^ b;
            execPkg::ALU_NOR  : r.out = ~(a | b);
            execPkg::ALU_SLT  : r.out = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            execPkg::ALU_SLTU : r.out = (a < b) ? 32'd1 : 32'd0;
            execPkg::ALU_MUL  : r.out = a * b;   // Low half only
            execPkg::ALU_MOVN:
            begin
                r.out = a;
                r.en  = (b != 0);
            end
            execPkg::ALU_MOVZ:
            begin
                r.out = a;
                r.en  = (b == 0);
            end
            execPkg::ALU_CLZ, execPkg::ALU_CLO:
            begin
                while (k < 32 && a[31-k] == (f == execPkg::ALU_CLO))
                    k++;
                r.out = execPkg::word_t'(k);
            end
            default   : r.en = 1'b0;
        endcase
        r.fl.z = (r.out == 0);
        r.fl.n = r.out[31];
        return r;
    endfunction

    function automatic execPkg::issue_t mkOp(execPkg::aluFunc_e f, int rs, int rt,
                                             int rd, int sh);
        execPkg::issue_t op;
        op.func  = f;
        op.rs    = execPkg::regAddr_t'(rs);
        op.rt    = execPkg::regAddr_t'(rt);
        op.rd    = execPkg::regAddr_t'(rd);
        op.shamt = execPkg::shamt_t'(sh);
        return op;
    endfunction

    function automatic execPkg::wbReq_t mkWb(logic v, execPkg::issue_t op, execPkg::word_t d);
        execPkg::wbReq_t w;
        w.valid = v;
        w.rd    = op.rd;
        w.data  = d;
        return w;
    endfunction

    // -------------------- Compare tasks
    task automatic checkWb(string name, execPkg::wbReq_t exp, execPkg::wbReq_t act);
        if (exp.valid !== act.valid ||
            (exp.valid && (exp.rd !== act.rd || exp.data !== act.data)))
        begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic checkFlags(string name, execPkg::flags_t exp, execPkg::flags_t act);
        if (exp !== act)
        begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act)
        begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic endTest(string name, int errBefore);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errBefore) ? "ok" : "FAIL");
    endtask

    // Starts and ends on a falling edge
    task automatic runOp(execPkg::issue_t op, int gap);
        aluRes_t         r;
        execPkg::wbReq_t exp;
        logic            trap;
        logic            isMul;
        int              lat;
        r     = refAlu(op.func, model[op.rs], model[op.rt], op.shamt);
        isMul = (op.func == execPkg::ALU_MUL);
        trap  = !isMul && (op.func == execPkg::ALU_ADD || op.func == execPkg::ALU_SUB) && r.fl.o;
        exp   = mkWb(r.en && !trap && (op.rd != 0), op, r.out);
        issue      = op;
        issueValid = 1'b1;
        while (stall)
            @(negedge clk);
        @(negedge clk);
        issueValid = 1'b0;
        lat        = 1;
        if (isMul)
        begin
            while (!commit.valid && lat < `EXEC_MULSTAGES + 2)
            begin
                @(negedge clk);
                lat++;
            end
            if (lat != `EXEC_MULSTAGES)
            begin
                $display("MUL result did not commit %0d cycles after accept", `EXEC_MULSTAGES);
                errors++;
            end
        end
        else
        begin
            checkBit("ovfTrap", trap, ovfTrap);
            checkFlags("condFlags", r.fl, condFlags);
            checkBit("stall", 1'b0, stall);
        end
        checkWb("commit", exp, commit);
        if (exp.valid)
            model[op.rd] = exp.data;
        repeat (gap + 1) @(negedge clk);
    endtask

    // Three MULs on consecutive cycles
    task automatic mulBurst();
        execPkg::issue_t ops [3];
        execPkg::wbReq_t exp [3];
        ops[0] = mkOp(execPkg::ALU_MUL, 5, 6, 9, 0);
        ops[1] = mkOp(execPkg::ALU_MUL, 7, 8, 10, 0);
        ops[2] = mkOp(execPkg::ALU_MUL, 6, 7, 11, 0);
        for (int k = 0; k < 3; k++)
            exp[k] = mkWb(1'b1, ops[k], model[ops[k].rs] * model[ops[k].rt]);
        for (int c = 0; c < 8; c++)
        begin
            if (c >= 3 && c < 6)
                checkWb("commit", exp[c-3], commit);
            else
                checkBit("commit.valid", 1'b0, commit.valid);
            issueValid = (c < 3);
            if (c < 3)
                issue = ops[c];
            @(negedge clk);
        end
        for (int k = 0; k < 3; k++)
            model[exp[k].rd] = exp[k].data;
    endtask

    // ALU result lands on the MUL writeback cycle
    task automatic collision();
        execPkg::issue_t mulOp;
        execPkg::issue_t aluOp;
        execPkg::issue_t heldOp;
        execPkg::wbReq_t mulExp;
        execPkg::wbReq_t aluExp;
        execPkg::wbReq_t heldExp;
        mulOp   = mkOp(execPkg::ALU_MUL, 5, 8, 12, 0);
        aluOp   = mkOp(execPkg::ALU_XOR, 5, 6, 13, 0);
        heldOp  = mkOp(execPkg::ALU_OR, 7, 8, 14, 0);
        mulExp  = mkWb(1'b1, mulOp, model[5] * model[8]);
        aluExp  = mkWb(1'b1, aluOp, model[5] ^ model[6]);
        heldExp = mkWb(1'b1, heldOp, model[7] | model[8]);
        issue      = mulOp;
        issueValid = 1'b1;
        @(negedge clk);
        issueValid = 1'b0;
        @(negedge clk);
        issue      = aluOp;
        issueValid = 1'b1;
        @(negedge clk);
        checkWb("commit", mulExp, commit);
        checkBit("stall", 1'b1, stall);
        issue = heldOp;   // Held until stall drops
        @(negedge clk);
        checkWb("commit", aluExp, commit);
        checkBit("stall", 1'b0, stall);
        @(negedge clk);
        issueValid = 1'b0;
        checkWb("commit", heldExp, commit);
        model[12] = mulExp.data;
        model[13] = aluExp.data;
        model[14] = heldExp.data;
        @(negedge clk);
    endtask

    task automatic fillTable();
        opTable.push_back('{mkOp(execPkg::ALU_ADD,  5, 6,  9,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_ADDU, 5, 6, 10,  0), 1});
        opTable.push_back('{mkOp(execPkg::ALU_SUB,  5, 7, 11,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SUBU, 7, 8, 12,  0), 2});
        opTable.push_back('{mkOp(execPkg::ALU_AND,  5, 6, 13,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_OR,   5, 6, 14,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_XOR,  5, 6, 15,  0), 1});
        opTable.push_back('{mkOp(execPkg::ALU_NOR,  5, 8, 16,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SLL,  0, 5, 17,  7), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SRL,  0, 4, 18,  4), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SRA,  0, 4, 19,  4), 2});
        opTable.push_back('{mkOp(execPkg::ALU_SLLV, 2, 6, 20,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SRLV, 7, 1, 21,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SRAV, 8, 4, 22,  0), 1});
        opTable.push_back('{mkOp(execPkg::ALU_SLT,  4, 3, 23,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SLT,  3, 4, 24,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SLTU, 4, 3, 25,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SLTU, 2, 1, 26,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_CLZ,  0, 0, 27,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_CLZ,  2, 0, 28,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_CLO,  1, 0, 29,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_CLO,  4, 0, 30,  0), 1});
        opTable.push_back('{mkOp(execPkg::ALU_MOVN, 5, 2, 31,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_MOVN, 6, 0, 31,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_MOVZ, 6, 0,  9,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_MOVZ, 7, 1,  9,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_ADD,  3, 2, 12,  0), 0});   // Overflow
        opTable.push_back('{mkOp(execPkg::ALU_ADDU, 3, 2, 12,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_SUB,  4, 2, 13,  0), 0});   // Overflow
        opTable.push_back('{mkOp(execPkg::ALU_ADDU, 5, 6,  0,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_OR,   0, 5, 14,  0), 0});
        opTable.push_back('{mkOp(execPkg::ALU_MUL,  5, 6, 10,  0), 0});
    endtask

    // -------------------- Main sequence
    initial
    begin
        int             errBefore;
        execPkg::word_t v;
        clk        = 1'b0;
        arstN      = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        seed       = 14;
        errors     = 0;
        tests      = 0;
        cycles     = 0;
        for (int i = 0; i < `EXEC_NREGS; i++)
            model[i] = '0;
        fillTable();

        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        errBefore = errors;
        checkBit("commit.valid", 1'b0, commit.valid);
        checkBit("stall", 1'b0, stall);
        checkBit("ovfTrap", 1'b0, ovfTrap);
        checkFlags("condFlags", '0, condFlags);
        endTest("reset", errBefore);

        // Constants from r0, then random values built bit by bit
        errBefore = errors;
        runOp(mkOp(execPkg::ALU_NOR, 0, 0, 1, 0), 0);
        runOp(mkOp(execPkg::ALU_SRL, 0, 1, 2, 31), 0);
        runOp(mkOp(execPkg::ALU_SRL, 0, 1, 3, 1), 0);
        runOp(mkOp(execPkg::ALU_SLL, 0, 2, 4, 31), 0);
        for (int r = 5; r <= 8; r++)
        begin
            v = $random(seed);
            for (int b = 31; b >= 0; b--)
            begin
                runOp(mkOp(execPkg::ALU_SLL, 0, r, r, 1), 0);
                if (v[b])
                    runOp(mkOp(execPkg::ALU_OR, r, 2, r, 0), 0);
            end
        end
        endTest("preload", errBefore);

        foreach (opTable[i])
        begin
            errBefore = errors;
            runOp(opTable[i].op, opTable[i].gap);
            endTest(opTable[i].op.func.name(), errBefore);
        end

        errBefore = errors;
        mulBurst();
        endTest("mulBurst", errBefore);

        errBefore = errors;
        collision();
        endTest("collision", errBefore);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
